/* testbench/bird_testdata.txt */
# random deploy speed damage life shot shot_x shot_y player_x exp_x exp_alive frames
# exp_x and exp_alive are the bird state right after the frame, frames repeats the line
100 1 0 1 5 0 0 0 0 280 1 1
2 0 0 1 5 0 0 0 0 280 1 1
100 0 0 1 5 0 0 0 0 281 1 1
100 0 1 1 5 0 0 0 0 282 1 1
100 0 1 1 5 0 0 0 0 284 1 1
100 0 2 1 5 0 0 0 0 286 1 1
100 0 3 1 5 0 0 0 0 288 1 1
5 0 3 1 5 0 0 0 0 291 1 1
6 0 0 1 5 0 0 0 0 291 1 1
100 0 2 1 5 0 0 0 0 289 1 1
100 0 2 1 5 0 0 0 0 287 1 1
250 0 0 1 5 0 0 0 0 286 1 1
3 0 0 1 5 0 0 0 0 285 1 1
100 0 0 2 5 1 300 200 0 285 1 1
100 0 0 2 5 1 300 200 0 285 1 1
100 0 0 2 5 1 100 200 0 285 1 1
100 0 0 2 5 0 0 0 0 285 1 30
100 0 0 3 5 1 300 200 0 285 1 1
100 0 0 3 5 0 0 0 0 285 1 19
100 0 0 3 5 0 0 0 290 285 1 1
100 0 0 3 5 0 0 0 0 285 1 11
100 0 0 3 5 0 0 0 0 285 0 1
100 0 0 3 5 1 300 200 0 285 0 1
100 1 0 3 2 1 300 200 0 285 1 1
250 0 0 3 2 0 0 0 0 285 1 1
100 0 0 3 2 0 0 0 0 285 1 2

/* build.f */
hdl/bird_pkg.sv
hdl/bird_motion.sv
hdl/dropping_motion.sv
hdl/hit_judge.sv
hdl/bird_game_core.sv
testbench/bird_checker.sv
testbench/tb_bird_game.sv

/* testbench/tb_bird_game.sv */
module tb_bird_game;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period   = 20;
	localparam int frame_cycles = 8; // clock edges spent on one frame line

	// one line of the testdata file
	typedef struct packed {
		int rnd;
		int deploy;
		int speed;
		int damage;
		int life;
		int shot;
		int shot_x;
		int shot_y;
		int player_x;
		int exp_x;
		int exp_alive;
		int count; // frames this line is repeated
	} frame_t;

	logic                   clk;
	logic                   resetN;
	logic                   start_of_frame;
	bird_pkg::rand_t        random;
	logic                   deploy;
	bird_pkg::speed_t       speed;
	bird_pkg::damage_t      damage;
	bird_pkg::life_t        starting_life;
	logic                   shot;
	bird_pkg::point_t       shot_pos;
	bird_pkg::coord_t       player_x;
	bird_pkg::bird_status_t bird;
	logic                   drop_active;
	bird_pkg::point_t       drop_pos;
	logic                   player_hit;
	bird_pkg::coord_t       exp_x;     // expected bird x after the frame
	logic                   exp_alive;
	int                     error_count;
	frame_t                 frames[$];
	int                     total_frames = 0;
	logic                   loaded = 1'b0;
	logic                   file_ok;   // testdata file could be opened

	bird_game_core #(
		.drop_cooldown (3)
	) u_bird_game_core (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.random         (random),
		.deploy         (deploy),
		.speed          (speed),
		.damage         (damage),
		.starting_life  (starting_life),
		.shot           (shot),
		.shot_pos       (shot_pos),
		.player_x       (player_x),
		.bird           (bird),
		.drop_active    (drop_active),
		.drop_pos       (drop_pos),
		.player_hit     (player_hit)
	);

	bird_checker u_bird_checker (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.random         (random),
		.deploy         (deploy),
		.damage         (damage),
		.starting_life  (starting_life),
		.shot           (shot),
		.shot_pos       (shot_pos),
		.player_x       (player_x),
		.bird           (bird),
		.drop_active    (drop_active),
		.drop_pos       (drop_pos),
		.player_hit     (player_hit),
		.exp_x          (exp_x),
		.exp_alive      (exp_alive),
		.error_count    (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic load_testdata(output logic ok);
		int     fd;
		int     n;
		int     v[12];
		string  line;
		frame_t f;
		fd = $fopen("testbench/bird_testdata.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd)) begin
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue; // header or blank line
				end
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
					v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
				if (n == 12) begin
					f = '{v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
						v[10], v[11]};
					frames.push_back(f);
					total_frames += v[11];
				end
			end
			$fclose(fd);
		end
	endtask

	// shot two cycles ahead of the strobe, then the frame strobe and idle cycles
	task automatic run_frame(input frame_t f);
		@(posedge clk);
		random        <= bird_pkg::rand_t'(f.rnd);
		deploy        <= f.deploy[0];
		speed         <= bird_pkg::speed_t'(f.speed);
		damage        <= bird_pkg::damage_t'(f.damage);
		starting_life <= bird_pkg::life_t'(f.life);
		shot          <= f.shot[0];
		shot_pos      <= '{x: bird_pkg::coord_t'(f.shot_x), y: bird_pkg::coord_t'(f.shot_y)};
		player_x      <= bird_pkg::coord_t'(f.player_x);
		exp_x         <= bird_pkg::coord_t'(f.exp_x);
		exp_alive     <= f.exp_alive[0];
		@(posedge clk);
		shot <= 1'b0;
		@(posedge clk);
		start_of_frame <= 1'b1;
		@(posedge clk);
		start_of_frame <= 1'b0;
		repeat (frame_cycles - 4) @(posedge clk);
	endtask

	initial begin
		resetN         = 1'b0;
		start_of_frame = 1'b0;
		random         = '0;
		deploy         = 1'b0;
		speed          = '0;
		damage         = '0;
		starting_life  = '0;
		shot           = 1'b0;
		shot_pos       = '0;
		player_x       = '0;
		exp_x          = '0;
		exp_alive      = 1'b0;
		load_testdata(file_ok);
		if (!file_ok) begin
			$display("cannot open testbench/bird_testdata.txt, no stimulus to run");
			$display("Regression failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (2) @(posedge clk);
			resetN <= 1'b1;
			foreach (frames[i]) begin
				for (int k = 0; k < frames[i].count; k++) begin
					run_frame(frames[i]);
				end
			end
			repeat (2) @(posedge clk); // last compare lands here
			$display("%0d frames run, %0d errors", total_frames, error_count);
			if (error_count == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end

	// watchdog sized from the number of frames in the file
	initial begin
		wait (loaded);
		#((total_frames * frame_cycles + 8) * clk_period + 1000);
		$display("timeout, the frames did not finish in time");
		$display("Regression failed");
		$finish;
	end

endmodule

/* testbench/bird_checker.sv */
module bird_checker (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_of_frame,
	input  bird_pkg::rand_t        random,
	input  logic                   deploy,
	input  bird_pkg::damage_t      damage,
	input  bird_pkg::life_t        starting_life,
	input  logic                   shot,
	input  bird_pkg::point_t       shot_pos,
	input  bird_pkg::coord_t       player_x,
	input  bird_pkg::bird_status_t bird,
	input  logic                   drop_active,
	input  bird_pkg::point_t       drop_pos,
	input  logic                   player_hit,
	input  bird_pkg::coord_t       exp_x,
	input  logic                   exp_alive,
	output int                     error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int   errors = 0;
	logic frame_seen = 1'b0;  // strobe sampled before the last edge
	logic hit_due = 1'b0;     // player_hit expected after this frame edge
	logic release_due = 1'b0; // dropping expected to start after this frame
	logic hit_pending = 1'b0; // shot landed on the bird since the last frame
	logic mdl_active = 1'b0;  // model of the falling dropping
	int   mdl_x;
	int   mdl_y;
	int   mdl_life = 0;       // model of the bird life points
	int   red_left = 0;       // frames of flashing left
	int   cool_left = 3;      // frames until a dropping may go again
	int   cur_x = 280;        // expected bird x for the running frame
	logic cur_alive = 1'b0;
	int   since_frame = 99;   // negedges since the last frame result

	assign error_count = errors;

	// 8x8 dropping against the 32x32 player box
	function automatic logic overlaps(input int dx, input int dy, input int px);
		return (dx < px + 32) && (dx + 8 > px) && (dy < 440 + 32) && (dy + 8 > 440);
	endfunction

	// shot point inside the 32x32 bird box on row 185
	function automatic logic in_bird_box(input bird_pkg::point_t p, input int bx);
		return (p.x >= bx) && (p.x < bx + 32) && (p.y >= 185) && (p.y < 185 + 32);
	endfunction

	task automatic fail_value(input string msg);
		errors++;
		$display("FAIL at %0t: %s", $time, msg);
	endtask

	always @(negedge clk) begin // sampled away from the edges
		if (!resetN) begin
			if (bird.pos.x != 280 || bird.pos.y != 185 || bird.alive || bird.red)
				fail_value("bird not at its reset values");
			if (drop_active || player_hit)
				fail_value("dropping or player hit active in reset");
			mdl_active  = 1'b0;
			frame_seen  = 1'b0;
			since_frame = 99;
			hit_pending = 1'b0;
			release_due = 1'b0;
			mdl_life    = 0;
			red_left    = 0;
			cool_left   = 3;
			cur_x       = 280;
			cur_alive   = 1'b0;
		end else begin
			if (shot && cur_alive && in_bird_box(shot_pos, cur_x))
				hit_pending = 1'b1;
			if (frame_seen) begin
				if (hit_pending && red_left == 0) begin // hit taken, outranks deploy
					mdl_life = (mdl_life > damage) ? mdl_life - damage : 0;
					red_left = 32;
				end else begin
					if (red_left != 0)
						red_left--;
					if (deploy)
						mdl_life = starting_life;
				end
				if (release_due)
					cool_left = 3;
				else if (cool_left != 0)
					cool_left--;
				hit_pending = 1'b0;
				if (bird.pos.x != exp_x || bird.pos.y != 185)
					fail_value($sformatf("bird at %0d,%0d, expected %0d,185",
						bird.pos.x, bird.pos.y, exp_x));
				if (bird.alive != exp_alive)
					fail_value($sformatf("alive %0b, expected %0b", bird.alive, exp_alive));
				if (bird.red != (red_left != 0))
					fail_value($sformatf("red %0b, expected %0b", bird.red, red_left != 0));
				if (player_hit != hit_due)
					fail_value($sformatf("player_hit %0b, expected %0b", player_hit, hit_due));
				if (mdl_active) begin // fall step of this frame
					if (mdl_y + 4 >= 480)
						mdl_active = 1'b0;
					else
						mdl_y = mdl_y + 4;
				end
				cur_x       = exp_x;
				cur_alive   = exp_alive;
				since_frame = 0;
			end else begin
				since_frame++;
				if (player_hit)
					fail_value("player_hit high longer than one cycle");
				if (since_frame == 1 && release_due && !mdl_active) begin // fresh dropping
					mdl_x = cur_x + 12;
					mdl_y = 185 + 32;
					mdl_active = 1'b1;
				end
			end
			if (drop_active != mdl_active) begin
				fail_value($sformatf("drop_active %0b, expected %0b", drop_active, mdl_active));
			end else if (mdl_active && (drop_pos.x != mdl_x || drop_pos.y != mdl_y)) begin
				fail_value($sformatf("dropping at %0d,%0d, expected %0d,%0d",
					drop_pos.x, drop_pos.y, mdl_x, mdl_y));
			end
			if (start_of_frame) begin
				hit_due     = mdl_active && overlaps(mdl_x, mdl_y, player_x);
				release_due = (mdl_life != 0) && (cool_left == 0) && (random > 240);
			end
			frame_seen = start_of_frame;
		end
	end

endmodule

/* hdl/bird_game_core.sv */
module bird_game_core #(
	parameter int random_offset = 0,
	parameter int drop_cooldown = 100,
	parameter int fall_step     = 4
) (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_of_frame,
	input  bird_pkg::rand_t        random,
	input  logic                   deploy,
	input  bird_pkg::speed_t       speed,
	input  bird_pkg::damage_t      damage,
	input  bird_pkg::life_t        starting_life,
	input  logic                   shot,
	input  bird_pkg::point_t       shot_pos,
	input  bird_pkg::coord_t       player_x,
	output bird_pkg::bird_status_t bird,
	output logic                   drop_active,
	output bird_pkg::point_t       drop_pos,
	output logic                   player_hit
);

	logic drop_release; // bird lets a dropping go
	logic bird_hit;     // pending shot on the bird

	bird_motion #(
		.random_offset (random_offset),
		.drop_cooldown (drop_cooldown)
	) u_bird_motion (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.random         (random),
		.deploy         (deploy),
		.speed          (speed),
		.damage         (damage),
		.starting_life  (starting_life),
		.bird_hit       (bird_hit),
		.bird           (bird),
		.drop_release   (drop_release)
	);

	dropping_motion #(
		.fall_step (fall_step)
	) u_dropping_motion (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.drop_release   (drop_release),
		.bird_pos       (bird.pos),
		.drop_active    (drop_active),
		.drop_pos       (drop_pos)
	);

	hit_judge u_hit_judge (
		.clk            (clk),
		.resetN         (resetN),
		.start_of_frame (start_of_frame),
		.shot           (shot),
		.shot_pos       (shot_pos),
		.bird           (bird),
		.drop_active    (drop_active),
		.drop_pos       (drop_pos),
		.player_x       (player_x),
		.bird_hit       (bird_hit),
		.player_hit     (player_hit)
	);

endmodule

/* hdl/hit_judge.sv */
module hit_judge (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_of_frame,
	input  logic                   shot,
	input  bird_pkg::point_t       shot_pos,
	input  bird_pkg::bird_status_t bird,
	input  logic                   drop_active,
	input  bird_pkg::point_t       drop_pos,
	input  bird_pkg::coord_t       player_x,
	output logic                   bird_hit,
	output logic                   player_hit
);

	int   bx; // bird box corner
	int   by;
	int   dx; // dropping box corner
	int   dy;
	int   px; // player box left edge
	logic shot_lands;
	logic drop_over_player;

	always_comb begin
		bx = bird.pos.x;
		by = bird.pos.y;
		dx = drop_pos.x;
		dy = drop_pos.y;
		px = player_x;
		// point inside the bird box, only a live bird can be hit
		shot_lands = shot && bird.alive &&
			(shot_pos.x >= bx) && (shot_pos.x < bx + bird_pkg::image_size) &&
			(shot_pos.y >= by) && (shot_pos.y < by + bird_pkg::image_size);
		// box overlap of dropping and player
		drop_over_player = drop_active &&
			(dx < px + bird_pkg::image_size) && (dx + bird_pkg::drop_size > px) &&
			(dy < bird_pkg::player_y + bird_pkg::image_size) &&
			(dy + bird_pkg::drop_size > bird_pkg::player_y);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bird_hit   <= 1'b0;
			player_hit <= 1'b0;
		end else begin
			player_hit <= start_of_frame && drop_over_player; // one cycle after the edge
			if (start_of_frame) begin
				bird_hit <= shot_lands; // old hit consumed now, keep one arriving this cycle
			end else if (shot_lands) begin
				bird_hit <= 1'b1;
			end
		end
	end

	a_player_hit_pulse: assert property (@(posedge clk) disable iff (!resetN)
		player_hit |=> !player_hit)
		else $error("player_hit held longer than one cycle");

endmodule

/* hdl/dropping_motion.sv */
module dropping_motion #(
	parameter int fall_step = 4 // pixels per frame
) (
	input  logic             clk,
	input  logic             resetN,
	input  logic             start_of_frame,
	input  logic             drop_release,
	input  bird_pkg::point_t bird_pos,
	output logic             drop_active,
	output bird_pkg::point_t drop_pos
);

	// centre the dropping under the bird sprite
	localparam int drop_x_offset = (bird_pkg::image_size - bird_pkg::drop_size) / 2;

	int y_next; // y after one more fall step

	assign y_next = int'(drop_pos.y) + fall_step;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drop_active <= 1'b0;
			drop_pos    <= '0;
		end else begin
			if (!drop_active && drop_release) begin // release while busy is lost
				drop_pos.x  <= bird_pos.x + bird_pkg::coord_t'(drop_x_offset);
				drop_pos.y  <= bird_pos.y + bird_pkg::coord_t'(bird_pkg::image_size);
				drop_active <= 1'b1;
			end else if (drop_active && start_of_frame) begin
				if (y_next >= bird_pkg::screen_height) begin
					drop_active <= 1'b0; // fell off the bottom
				end else begin
					drop_pos.y <= bird_pkg::coord_t'(y_next);
				end
			end
		end
	end

	a_drop_on_screen: assert property (@(posedge clk) disable iff (!resetN)
		drop_active |-> (drop_pos.y < bird_pkg::screen_height))
		else $error("active dropping below the screen");

endmodule

/* hdl/bird_motion.sv */
module bird_motion #(
	parameter int random_offset = 0,  // lets several birds share one random source
	parameter int drop_cooldown = 100 // frames between two droppings
) (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   start_of_frame,
	input  bird_pkg::rand_t        random,
	input  logic                   deploy,
	input  bird_pkg::speed_t       speed,
	input  bird_pkg::damage_t      damage,
	input  bird_pkg::life_t        starting_life,
	input  logic                   bird_hit,
	output bird_pkg::bird_status_t bird,
	output logic                   drop_release
);

	typedef enum logic [1:0] {st_idle, st_right, st_left} dir_t;

	localparam int left_turn_px  = 2 * bird_pkg::image_size; // forced right below this
	localparam int right_turn_px = bird_pkg::screen_width - 2 * bird_pkg::image_size - 1;
	localparam int right_stop_px = bird_pkg::screen_width - bird_pkg::image_size - 1;

	dir_t              state;
	dir_t              next_state;
	bird_pkg::fixed_t  x_fix;   // sub-pixel x
	bird_pkg::fixed_t  step;    // per-frame move in fixed units
	bird_pkg::coord_t  x_pix;   // whole pixels
	bird_pkg::life_t   life;
	logic [5:0]        red_cnt; // frames left to flash
	logic [15:0]       cooldown; // frames until a drop is allowed again
	int                r;       // offset random value
	logic              red;
	logic              release_now;

	always_comb begin
		r = int'(random) + random_offset;
		if (r > 255) begin
			r = r - 255; // wrap back into a byte
		end
	end

	assign step  = bird_pkg::fixed_t'(64 + 32 * speed); // 1, 1.5, 2, 2.5 px
	assign x_pix = bird_pkg::coord_t'(x_fix >> bird_pkg::frac_bits);
	assign red   = red_cnt != 0;

	assign release_now = (life != 0) && (cooldown == 0) && (r > bird_pkg::drop_threshold);

	// direction choice, applied on the next frame
	always_comb begin
		next_state = state;
		if (r < bird_pkg::change_chance) begin
			if (state == st_idle) begin
				if (x_pix < left_turn_px) begin
					next_state = st_right; // too close to the left wall
				end else if (x_pix > right_turn_px) begin
					next_state = st_left;  // too close to the right wall
				end else if (r < bird_pkg::change_chance / 2) begin
					next_state = st_right; // lower half of the chance band
				end else begin
					next_state = st_left;
				end
			end else begin
				next_state = st_idle; // a moving bird always pauses first
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state        <= st_idle;
			x_fix        <= bird_pkg::fixed_t'(bird_pkg::initial_x << bird_pkg::frac_bits);
			life         <= '0;
			red_cnt      <= '0;
			cooldown     <= 16'(drop_cooldown);
			drop_release <= 1'b0;
		end else begin
			drop_release <= 1'b0; // one-cycle pulse
			if (start_of_frame) begin
				state    <= next_state;
				red_cnt  <= red ? red_cnt - 6'd1 : '0;
				cooldown <= (cooldown != 0) ? cooldown - 16'd1 : '0;

				case (state) // moves with the direction held during this frame
				st_right: begin
					if (x_pix < right_stop_px) begin
						x_fix <= x_fix + step;
					end
				end
				st_left: begin
					if (x_fix >= (step << 1)) begin
						x_fix <= x_fix - step;
					end
				end
				default: x_fix <= x_fix; // idle hovers
				endcase

				if (bird_hit && !red) begin // hits while flashing are ignored
					life    <= (life > bird_pkg::life_t'(damage)) ?
						life - bird_pkg::life_t'(damage) : '0;
					red_cnt <= 6'(bird_pkg::red_frames);
				end else if (deploy) begin
					life <= starting_life;
				end

				if (release_now) begin
					drop_release <= 1'b1;
					cooldown     <= 16'(drop_cooldown); // restart the wait
				end
			end
		end
	end

	always_comb begin
		bird.pos.x = x_pix;
		bird.pos.y = bird_pkg::coord_t'(bird_pkg::initial_y); // fixed row
		bird.alive = (life != 0) || red; // keeps flashing after the last hit
		bird.red   = red;
	end

	a_release_after_frame: assert property (@(posedge clk) disable iff (!resetN)
		$rose(drop_release) |-> $past(start_of_frame))
		else $error("drop_release rose outside the cycle after a frame strobe");

endmodule

/* hdl/bird_pkg.sv */
package bird_pkg;

	typedef logic signed [10:0] coord_t; // pixel coordinate, signed so edge math can dip below 0
	typedef logic [16:0]        fixed_t; // x in 1/64 pixel, 639*64 still fits
	typedef logic [7:0]         rand_t;  // one byte from the random source
	typedef logic [3:0]         life_t;  // life points, up to 15
	typedef logic [1:0]         speed_t; // 0..3, adds half a pixel per step each
	typedef logic [1:0]         damage_t; // life lost per accepted hit

	typedef struct packed {
		coord_t x; // left edge
		coord_t y; // top edge
	} point_t;

	// what the rest of the game sees of the bird
	typedef struct packed {
		point_t pos;
		logic   alive; // life left or still flashing
		logic   red;   // flashing after a hit
	} bird_status_t;

	localparam int screen_width  = 640;
	localparam int screen_height = 480;

	localparam int image_size = 32; // bird sprite and player box side
	localparam int drop_size  = 8;  // dropping box side

	localparam int frac_bits = 6; // 64 fixed units per pixel

	localparam int initial_x = 280;
	localparam int initial_y = 185; // row never changes

	localparam int red_frames = 32; // flash length after a hit

	localparam int change_chance  = 8;   // r below this lets the direction change
	localparam int drop_threshold = 240; // r above this lets a dropping go

	localparam int player_y = 440; // top edge of the player box

endpackage
